/* build.f */
hdl/pdec_pkg.sv
hdl/pdec_bit_seq.sv
hdl/pdec_dec_bit.sv
hdl/pdec_dcrc_path.sv
hdl/pdec_updt_path.sv
verification/pdec_updt_path_props.sv
verification/pdec_updt_path_tb.sv

/* Bender.yml */
package:
  name: pdec_updt_path

sources:
  - hdl/pdec_pkg.sv
  - hdl/pdec_bit_seq.sv
  - hdl/pdec_dec_bit.sv
  - hdl/pdec_dcrc_path.sv
  - hdl/pdec_updt_path.sv
  - target: test
    files:
      - verification/pdec_updt_path_props.sv
      - verification/pdec_updt_path_tb.sv

/* verification/pdec_updt_path_tb.sv */
// ============================================================
// directed tests of the path update stage against a reference
// model of list writes, parity and status
// ============================================================
`timescale 1ns/1ps

module pdec_updt_path_tb;

  logic                                           clk;
  logic                                           rst_n;
  pdec_pkg::node_cfg_t                            node_cfg;
  logic                                           dec_start;
  logic                                           upd_valid;
  pdec_pkg::path_bmp_t                            srvl_bmp;
  pdec_pkg::pm_idx_t    [pdec_pkg::num_path-1:0]  pm_idx;
  pdec_pkg::leaf_bits_t [pdec_pkg::num_cand-1:0]  bit_val;
  pdec_pkg::dcrc_vec_t  [pdec_pkg::num_k-1:0]     dcrc_info;
  logic                                           upd_ready;
  logic                                           upd_done;
  logic                                           early_term;
  pdec_pkg::list_wr_t                             list_wr;
  pdec_pkg::path_stat_e [pdec_pkg::num_path-1:0]  path_stat;

  // reference model state
  pdec_pkg::path_stat_e m_stat [pdec_pkg::num_path];
  pdec_pkg::dcrc_vec_t  m_par  [pdec_pkg::num_path];
  int                   m_cnt;
  int                   err_cnt;
  int                   test_cnt;

  pdec_updt_path pdec_updt_path_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .node_cfg   (node_cfg),
    .dec_start  (dec_start),
    .upd_valid  (upd_valid),
    .srvl_bmp   (srvl_bmp),
    .pm_idx     (pm_idx),
    .bit_val    (bit_val),
    .dcrc_info  (dcrc_info),
    .upd_ready  (upd_ready),
    .upd_done   (upd_done),
    .list_wr    (list_wr),
    .path_stat  (path_stat),
    .early_term (early_term)
  );

  bind pdec_updt_path pdec_updt_path_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .upd_valid (upd_valid),
    .upd_ready (upd_ready),
    .upd_done  (upd_done),
    .srvl_bmp  (srvl_bmp),
    .list_wr   (list_wr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ============================================================
  // helpers
  // ============================================================
  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR @%0t: %s got %0h expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err_cnt - err_before);
  endtask

  function automatic int steps_for(input logic leaf, input pdec_pkg::jump_type_e jt);
    int n;
    n = 1;
    if (leaf) begin
      if (jt == pdec_pkg::jt_bit2_t0 || jt == pdec_pkg::jt_bit2_t1) n = 2;
      else if (jt == pdec_pkg::jt_bit3) n = 3;
      else if (jt == pdec_pkg::jt_bit4) n = 4;
    end
    return n;
  endfunction

  // expected bit as the xor of the nibble bits picked by a mask
  function automatic logic model_bit(input logic leaf, input pdec_pkg::jump_type_e jt,
                                     input int s, input pdec_pkg::pm_idx_t pm,
                                     input pdec_pkg::leaf_bits_t b);
    logic [3:0] mask;
    mask = 4'b1000;                         // last step is always b3
    if (!leaf || jt == pdec_pkg::jt_rep) return pm[0];
    if (jt == pdec_pkg::jt_frozen) return 1'b0;
    case (jt)
      pdec_pkg::jt_bit2_t0: if (s == 0) mask = 4'b1010;
      pdec_pkg::jt_bit2_t1: if (s == 0) mask = 4'b1100;
      pdec_pkg::jt_bit3:    if (s < 2) mask = (s == 0) ? 4'b1010 : 4'b1100;
      pdec_pkg::jt_bit4: begin
        if (s == 0) mask = 4'b1111;
        else if (s == 1) mask = 4'b1010;
        else if (s == 2) mask = 4'b1100;
      end
      default: mask = 4'b1000;
    endcase
    return ^(b & mask);
  endfunction

  task automatic random_stim(output pdec_pkg::pm_idx_t [pdec_pkg::num_path-1:0] pm,
                             output pdec_pkg::leaf_bits_t [pdec_pkg::num_cand-1:0] bv);
    for (int i = 0; i < pdec_pkg::num_path; i++) pm[i] = $urandom % 32;
    for (int c = 0; c < pdec_pkg::num_cand; c++) bv[c] = $urandom % 16;
  endtask

  task automatic start_decode(input logic leaf, input pdec_pkg::dcrc_mode_e mode,
                              input logic [1:0] num, input pdec_pkg::dcrc_vec_t ini,
                              input pdec_pkg::info_cnt_t [pdec_pkg::num_dcrc-1:0] idx);
    @(posedge clk);
    #1;
    node_cfg.leaf_mode = leaf;
    node_cfg.jump_type = pdec_pkg::jt_normal;
    node_cfg.dcrc_num  = num;
    node_cfg.dcrc_mode = mode;
    node_cfg.dcrc_ini  = ini;
    node_cfg.dcrc_idx  = idx;
    dec_start = 1'b1;
    @(posedge clk);
    #1;
    dec_start = 1'b0;
    for (int i = 0; i < pdec_pkg::num_path; i++) begin
      m_par[i]  = ini;
      m_stat[i] = (i == 0) ? pdec_pkg::stat_valid : pdec_pkg::stat_invalid;
    end
    m_cnt = 0;
  endtask

  // ============================================================
  // one update request collected and checked against the model
  // ============================================================
  task automatic run_update(input pdec_pkg::jump_type_e jt, input pdec_pkg::path_bmp_t srvl,
                            input pdec_pkg::pm_idx_t [pdec_pkg::num_path-1:0] pm,
                            input pdec_pkg::leaf_bits_t [pdec_pkg::num_cand-1:0] bv);
    pdec_pkg::list_wr_t   got_wr[$];
    pdec_pkg::path_stat_e old_stat [pdec_pkg::num_path];
    pdec_pkg::dcrc_vec_t  old_par  [pdec_pkg::num_path];
    pdec_pkg::path_idx_t  par_idx  [pdec_pkg::num_path];
    pdec_pkg::dcrc_vec_t  num_mask;
    pdec_pkg::dcrc_vec_t  chk;
    logic                 b;
    logic                 all_inv;
    logic                 any_val;
    int                   nsteps;
    int                   lat;
    int                   tries;

    @(posedge clk);
    #1;
    node_cfg.jump_type = jt;
    srvl_bmp  = srvl;
    pm_idx    = pm;
    bit_val   = bv;
    upd_valid = 1'b1;
    tries = 0;
    @(negedge clk);
    while (!upd_ready && tries < 20) begin
      @(negedge clk);
      tries++;
    end
    if (!upd_ready) begin
      $display("timeout: upd_ready never rose for the update request");
      err_cnt++;
      @(posedge clk);
      #1;
      upd_valid = 1'b0;
      return;
    end
    // valid stays high, so a second accept would add writes
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      check_val("upd_ready while busy", upd_ready, 1'b0);
      if (list_wr.wen != '0) got_wr.push_back(list_wr);
    end while (!upd_done && lat < 12);
    if (!upd_done) begin
      $display("timeout: no upd_done within 12 cycles of acceptance");
      err_cnt++;
    end
    @(posedge clk);
    #1;
    upd_valid = 1'b0;

    nsteps = steps_for(node_cfg.leaf_mode, jt);
    check_val("done latency", lat, node_cfg.leaf_mode ? nsteps + 1 : 1);
    check_val("write count", got_wr.size(), nsteps);
    for (int i = 0; i < pdec_pkg::num_path; i++) begin
      old_stat[i] = m_stat[i];
      old_par[i]  = m_par[i];
      par_idx[i]  = (jt == pdec_pkg::jt_rep) ? pm[i][3:1] : pm[i][4:2];
    end
    for (int i = 0; i < pdec_pkg::num_path; i++) begin
      if (srvl[i]) begin
        m_par[i]  = old_par[par_idx[i]];
        m_stat[i] = (old_stat[par_idx[i]] == pdec_pkg::stat_ck) ? pdec_pkg::stat_ck
                                                                 : pdec_pkg::stat_valid;
      end else begin
        m_stat[i] = pdec_pkg::stat_invalid;
      end
    end
    for (int s = 0; s < nsteps; s++) begin
      for (int j = 0; j < pdec_pkg::num_dcrc; j++) begin
        num_mask[j] = (j < node_cfg.dcrc_num);
        chk[j]      = num_mask[j] && (m_cnt == node_cfg.dcrc_idx[j]);
      end
      if (s < got_wr.size()) begin
        check_val($sformatf("wen step %0d", s), got_wr[s].wen, srvl);
        check_val($sformatf("waddr step %0d", s), got_wr[s].waddr, m_cnt % 256);
      end
      for (int i = 0; i < pdec_pkg::num_path; i++) begin
        b = model_bit(node_cfg.leaf_mode, jt, s, pm[i], bv[pm[i]]);
        if (srvl[i]) begin
          if (m_cnt < pdec_pkg::num_k)
            m_par[i] = m_par[i] ^ (dcrc_info[m_cnt] & num_mask & {pdec_pkg::num_dcrc{b}});
          if ((chk & m_par[i]) != '0)
            m_stat[i] = (node_cfg.dcrc_mode == pdec_pkg::mode_cd) ? pdec_pkg::stat_invalid
                                                                   : pdec_pkg::stat_ck;
          if (s < got_wr.size()) begin
            check_val($sformatf("path %0d step %0d bit", i, s), got_wr[s].wdata[i].dec, b);
            check_val($sformatf("path %0d step %0d index", i, s), got_wr[s].wdata[i].idx,
                      (s == 0 || jt == pdec_pkg::jt_rep) ? par_idx[i] : i);
          end
        end
      end
      m_cnt++;
    end

    @(negedge clk);                         // check results have settled
    all_inv = 1'b1;
    any_val = 1'b0;
    for (int i = 0; i < pdec_pkg::num_path; i++) begin
      check_val($sformatf("path %0d status", i), path_stat[i], m_stat[i]);
      all_inv = all_inv & (m_stat[i] == pdec_pkg::stat_invalid);
      any_val = any_val | (m_stat[i] == pdec_pkg::stat_valid);
    end
    check_val("early_term", early_term,
              (node_cfg.dcrc_mode == pdec_pkg::mode_cd) ? all_inv : !any_val);
  endtask

  // ============================================================
  // tests
  // ============================================================
  task automatic test_non_leaf();
    pdec_pkg::pm_idx_t    [pdec_pkg::num_path-1:0] pm;
    pdec_pkg::leaf_bits_t [pdec_pkg::num_cand-1:0] bv;
    int                                            e0;
    e0 = err_cnt;
    start_decode(1'b0, pdec_pkg::mode_cd, 2'd0, 3'd0, '0);
    for (int n = 0; n < 4; n++) begin
      random_stim(pm, bv);
      run_update(pdec_pkg::jt_normal, pdec_pkg::path_bmp_t'($urandom % 255 + 1), pm, bv);
    end
    report_test("non-leaf updates", e0);
  endtask

  task automatic test_leaf();
    pdec_pkg::pm_idx_t    [pdec_pkg::num_path-1:0] pm;
    pdec_pkg::leaf_bits_t [pdec_pkg::num_cand-1:0] bv;
    pdec_pkg::jump_type_e                          jts [4];
    int                                            e0;
    e0 = err_cnt;
    jts[0] = pdec_pkg::jt_bit2_t0;
    jts[1] = pdec_pkg::jt_bit2_t1;
    jts[2] = pdec_pkg::jt_bit3;
    jts[3] = pdec_pkg::jt_bit4;
    start_decode(1'b1, pdec_pkg::mode_cd, 2'd0, 3'd0, '0);
    for (int t = 0; t < 4; t++) begin
      random_stim(pm, bv);
      run_update(jts[t], pdec_pkg::path_bmp_t'($urandom % 255 + 1), pm, bv);
    end
    report_test("leaf bit types", e0);
  endtask

  task automatic test_rep_frozen();
    pdec_pkg::pm_idx_t    [pdec_pkg::num_path-1:0] pm;
    pdec_pkg::leaf_bits_t [pdec_pkg::num_cand-1:0] bv;
    int                                            e0;
    e0 = err_cnt;
    start_decode(1'b1, pdec_pkg::mode_cd, 2'd0, 3'd0, '0);
    random_stim(pm, bv);
    run_update(pdec_pkg::jt_rep, 8'hff, pm, bv);
    random_stim(pm, bv);
    run_update(pdec_pkg::jt_frozen, 8'hff, pm, bv);
    report_test("repetition and frozen", e0);
  endtask

  // path 0 fails into ck, path 1 stays valid, then both are forked
  task automatic test_survival();
    pdec_pkg::pm_idx_t [pdec_pkg::num_path-1:0] pm;
    int                                         e0;
    e0 = err_cnt;
    start_decode(1'b0, pdec_pkg::mode_ck, 2'd1, 3'b001, {8'd0, 8'd0, 8'd0});
    dcrc_info    = '0;
    dcrc_info[0] = 3'b001;
    pm = '0;
    pm[1] = 5'b00001;
    run_update(pdec_pkg::jt_normal, 8'h03, pm, '0);
    pm = '0;
    pm[5] = 5'b00100;                       // parent 1
    pm[7] = 5'b00100;
    run_update(pdec_pkg::jt_normal, 8'hf0, pm, '0);
    report_test("survival", e0);
  endtask

  task automatic test_dcrc(input pdec_pkg::dcrc_mode_e mode);
    pdec_pkg::pm_idx_t [pdec_pkg::num_path-1:0] pm;
    int                                         e0;
    e0 = err_cnt;
    start_decode(1'b0, mode, 2'd2, 3'b000, {8'd0, 8'd2, 8'd1});
    dcrc_info    = '0;
    dcrc_info[0] = 3'b011;
    dcrc_info[1] = 3'b001;
    dcrc_info[2] = 3'b010;
    pm = '0;
    for (int i = 0; i < 4; i++) pm[i] = {3'd0, 1'b0, (i % 2 == 1)};  // odd paths flip parity
    run_update(pdec_pkg::jt_normal, 8'h0f, pm, '0);
    for (int i = 0; i < 4; i++) pm[i] = {pdec_pkg::path_idx_t'(i), 2'b00};
    run_update(pdec_pkg::jt_normal, 8'h0f, pm, '0);
    for (int i = 0; i < 4; i++) pm[i] = {pdec_pkg::path_idx_t'(i), 2'b01};
    run_update(pdec_pkg::jt_normal, 8'h05, pm, '0);
    check_val("early_term after last check", early_term, 1'b1);
    report_test((mode == pdec_pkg::mode_cd) ? "dcrc cd mode" : "dcrc ck mode", e0);
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    void'($urandom(32'hf2a6_d91d));
    err_cnt   = 0;
    test_cnt  = 0;
    rst_n     = 1'b0;
    node_cfg  = '0;
    dec_start = 1'b0;
    upd_valid = 1'b0;
    srvl_bmp  = '0;
    pm_idx    = '0;
    bit_val   = '0;
    dcrc_info = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_val("upd_ready after reset", upd_ready, 1'b1);
    check_val("upd_done after reset", upd_done, 1'b0);
    check_val("wen after reset", list_wr.wen, 8'h00);

    test_non_leaf();
    test_leaf();
    test_rep_frozen();
    test_survival();
    test_dcrc(pdec_pkg::mode_cd);
    test_dcrc(pdec_pkg::mode_ck);

    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* verification/pdec_updt_path_props.sv */
// ============================================================
// path update handshake and list write timing checks
// ============================================================
`timescale 1ns/1ps

module pdec_updt_path_props (
  input logic                clk,
  input logic                rst_n,
  input logic                upd_valid,
  input logic                upd_ready,
  input logic                upd_done,
  input pdec_pkg::path_bmp_t srvl_bmp,
  input pdec_pkg::list_wr_t  list_wr
);

  // busy right after an accept
  a_busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
    (upd_valid && upd_ready) |=> !upd_ready)
    else $error("upd_ready high in the cycle after acceptance");

  // stays busy until the done pulse
  a_busy_until_done: assert property (@(posedge clk) disable iff (!rst_n)
    (!upd_ready && !upd_done) |=> !upd_ready)
    else $error("upd_ready rose before upd_done");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    upd_done |=> !upd_done)
    else $error("upd_done longer than one cycle");

  a_wen_subset: assert property (@(posedge clk) disable iff (!rst_n)
    (list_wr.wen & ~srvl_bmp) == '0)
    else $error("list write to a path outside srvl_bmp");

endmodule

/* hdl/pdec_updt_path.sv */
// ============================================================
// polar list decoder path update stage, eight list paths
// ============================================================
`timescale 1ns/1ps

module pdec_updt_path (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  pdec_pkg::node_cfg_t                            node_cfg,
  input  logic                                           dec_start,
  input  logic                                           upd_valid,
  input  pdec_pkg::path_bmp_t                            srvl_bmp,
  input  pdec_pkg::pm_idx_t    [pdec_pkg::num_path-1:0]  pm_idx,
  input  pdec_pkg::leaf_bits_t [pdec_pkg::num_cand-1:0]  bit_val,
  input  pdec_pkg::dcrc_vec_t  [pdec_pkg::num_k-1:0]     dcrc_info,
  output logic                                           upd_ready,
  output logic                                           upd_done,
  output pdec_pkg::list_wr_t                             list_wr,
  output pdec_pkg::path_stat_e [pdec_pkg::num_path-1:0]  path_stat,
  output logic                                           early_term
);

  pdec_pkg::step_t                              step;
  pdec_pkg::path_bmp_t                          dec_bit;
  pdec_pkg::path_idx_t [pdec_pkg::num_path-1:0] parent;

  // step control
  pdec_bit_seq u_bit_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .node_cfg  (node_cfg),
    .dec_start (dec_start),
    .upd_valid (upd_valid),
    .upd_ready (upd_ready),
    .step      (step),
    .upd_done  (upd_done)
  );

  // decoded bits and list memory writes
  pdec_dec_bit u_dec_bit (
    .clk      (clk),
    .rst_n    (rst_n),
    .node_cfg (node_cfg),
    .step     (step),
    .srvl_bmp (srvl_bmp),
    .pm_idx   (pm_idx),
    .bit_val  (bit_val),
    .dec_bit  (dec_bit),
    .parent   (parent),
    .list_wr  (list_wr)
  );

  // parity, status, early stop
  pdec_dcrc_path u_dcrc_path (
    .clk        (clk),
    .rst_n      (rst_n),
    .node_cfg   (node_cfg),
    .dec_start  (dec_start),
    .step       (step),
    .srvl_bmp   (srvl_bmp),
    .dec_bit    (dec_bit),
    .parent     (parent),
    .dcrc_info  (dcrc_info),
    .path_stat  (path_stat),
    .early_term (early_term)
  );

endmodule

/* hdl/pdec_dcrc_path.sv */
// ============================================================
// distributed CRC parity per path, path status tracking and
// early termination
// ============================================================
`timescale 1ns/1ps

module pdec_dcrc_path (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  pdec_pkg::node_cfg_t                            node_cfg,
  input  logic                                           dec_start,
  input  pdec_pkg::step_t                                step,
  input  pdec_pkg::path_bmp_t                            srvl_bmp,
  input  pdec_pkg::path_bmp_t                            dec_bit,
  input  pdec_pkg::path_idx_t  [pdec_pkg::num_path-1:0]  parent,
  input  pdec_pkg::dcrc_vec_t  [pdec_pkg::num_k-1:0]     dcrc_info,
  output pdec_pkg::path_stat_e [pdec_pkg::num_path-1:0]  path_stat,
  output logic                                           early_term
);

  pdec_pkg::dcrc_vec_t  [pdec_pkg::num_path-1:0] dcrc_q;
  pdec_pkg::dcrc_vec_t  [pdec_pkg::num_path-1:0] dcrc_base;
  pdec_pkg::path_stat_e [pdec_pkg::num_path-1:0] stat_q;
  pdec_pkg::dcrc_vec_t                           num_mask;
  pdec_pkg::dcrc_vec_t                           info_mask;
  pdec_pkg::dcrc_vec_t                           chk_d;
  pdec_pkg::dcrc_vec_t                           chk_q;
  pdec_pkg::path_bmp_t                           chk_bmp_q;
  pdec_pkg::path_bmp_t                           fail;
  logic                                          all_invalid;
  logic                                          any_valid;

  // ============================================================
  // shared check and info masks
  // ============================================================
  always_comb begin
    for (int j = 0; j < pdec_pkg::num_dcrc; j++) begin
      num_mask[j] = (j < node_cfg.dcrc_num);
      chk_d[j]    = step.fire & (j < node_cfg.dcrc_num) &
                    (step.info_cnt == node_cfg.dcrc_idx[j]);
    end
  end

  // guard against info counts past the table
  assign info_mask = (step.fire && (step.info_cnt < pdec_pkg::num_k)) ?
                     (dcrc_info[step.info_cnt] & num_mask) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      chk_q     <= '0;
      chk_bmp_q <= '0;
    end else begin
      chk_q     <= chk_d;
      chk_bmp_q <= step.fire ? srvl_bmp : '0;  // paths that took a bit
    end
  end

  // ============================================================
  // per path parity and status
  // ============================================================
  for (genvar i = 0; i < pdec_pkg::num_path; i++) begin : g_path

    assign dcrc_base[i] = step.first ? dcrc_q[parent[i]] : dcrc_q[i];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        dcrc_q[i] <= '0;
      end else if (dec_start) begin
        dcrc_q[i] <= node_cfg.dcrc_ini;
      end else if (srvl_bmp[i] && (step.first || step.fire)) begin
        dcrc_q[i] <= dcrc_base[i] ^ (info_mask & {pdec_pkg::num_dcrc{dec_bit[i]}});
      end
    end

    // register already holds the updated parity here
    assign fail[i] = chk_bmp_q[i] & (|(chk_q & dcrc_q[i]));

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        stat_q[i] <= pdec_pkg::stat_invalid;
      end else if (dec_start) begin
        stat_q[i] <= (i == 0) ? pdec_pkg::stat_valid : pdec_pkg::stat_invalid;
      end else if (step.first) begin
        if (!srvl_bmp[i]) begin
          stat_q[i] <= pdec_pkg::stat_invalid;
        end else if (stat_q[parent[i]] == pdec_pkg::stat_ck) begin
          stat_q[i] <= pdec_pkg::stat_ck;    // inherit mark
        end else begin
          stat_q[i] <= pdec_pkg::stat_valid;
        end
      end else if (fail[i]) begin
        stat_q[i] <= (node_cfg.dcrc_mode == pdec_pkg::mode_cd) ?
                     pdec_pkg::stat_invalid : pdec_pkg::stat_ck;
      end
    end

  end

  assign path_stat = stat_q;

  // ============================================================
  // early termination
  // ============================================================
  always_comb begin
    all_invalid = 1'b1;
    any_valid   = 1'b0;
    for (int p = 0; p < pdec_pkg::num_path; p++) begin
      all_invalid = all_invalid & (stat_q[p] == pdec_pkg::stat_invalid);
      any_valid   = any_valid | (stat_q[p] == pdec_pkg::stat_valid);
    end
  end

  assign early_term = (node_cfg.dcrc_mode == pdec_pkg::mode_cd) ? all_invalid : ~any_valid;

endmodule

/* hdl/pdec_dec_bit.sv */
// ============================================================
// decoded bit datapath: parent index, leaf nibble capture and
// list memory writes for every path
// ============================================================
`timescale 1ns/1ps

module pdec_dec_bit (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  pdec_pkg::node_cfg_t                             node_cfg,
  input  pdec_pkg::step_t                                 step,
  input  pdec_pkg::path_bmp_t                             srvl_bmp,
  input  pdec_pkg::pm_idx_t    [pdec_pkg::num_path-1:0]   pm_idx,
  input  pdec_pkg::leaf_bits_t [pdec_pkg::num_cand-1:0]   bit_val,
  output pdec_pkg::path_bmp_t                             dec_bit,
  output pdec_pkg::path_idx_t  [pdec_pkg::num_path-1:0]   parent,
  output pdec_pkg::list_wr_t                              list_wr
);

  // leaf bit for a given step, b is {bit3,bit2,bit1,bit0}
  function automatic logic leaf_bit(input pdec_pkg::jump_type_e jt,
                                    input pdec_pkg::step_idx_t  idx,
                                    input pdec_pkg::leaf_bits_t b);
    logic r;
    r = 1'b0;
    case (jt)
      pdec_pkg::jt_bit2_t0: r = (idx == 2'd0) ? (b[3] ^ b[1]) : b[3];
      pdec_pkg::jt_bit2_t1: r = (idx == 2'd0) ? (b[3] ^ b[2]) : b[3];
      pdec_pkg::jt_bit3: begin
        case (idx)
          2'd0:    r = b[3] ^ b[1];
          2'd1:    r = b[3] ^ b[2];
          default: r = b[3];
        endcase
      end
      pdec_pkg::jt_bit4: begin
        case (idx)
          2'd0:    r = ^b;            // parity of all four
          2'd1:    r = b[3] ^ b[1];
          2'd2:    r = b[3] ^ b[2];
          default: r = b[3];
        endcase
      end
      default: r = 1'b0;   // frozen
    endcase
    return r;
  endfunction

  pdec_pkg::leaf_bits_t [pdec_pkg::num_path-1:0] nib_q;
  pdec_pkg::path_bmp_t                           wen_q;
  pdec_pkg::info_cnt_t                           waddr_q;
  pdec_pkg::list_ent_t  [pdec_pkg::num_path-1:0] wdata_q;
  logic                                          is_rep;
  logic                                          use_parent;

  assign is_rep     = (node_cfg.jump_type == pdec_pkg::jt_rep);
  assign use_parent = (step.idx == 2'd0) | is_rep;  // later leaf steps point to self

  // ============================================================
  // per path
  // ============================================================
  for (genvar i = 0; i < pdec_pkg::num_path; i++) begin : g_path

    // repetition sorts 16 candidates, the others 32
    assign parent[i] = is_rep ? pm_idx[i][3:1] : pm_idx[i][4:2];

    always_ff @(posedge clk) begin
      if (step.first && node_cfg.leaf_mode) begin
        nib_q[i] <= bit_val[pm_idx[i]];
      end
    end

    always_comb begin
      if (!node_cfg.leaf_mode || is_rep) begin
        dec_bit[i] = pm_idx[i][0];
      end else begin
        dec_bit[i] = leaf_bit(node_cfg.jump_type, step.idx, nib_q[i]);
      end
    end

    always_ff @(posedge clk) begin
      if (step.fire) begin
        wdata_q[i].dec <= dec_bit[i];
        wdata_q[i].idx <= use_parent ? parent[i] : pdec_pkg::path_idx_t'(i);
      end
    end

  end

  // ============================================================
  // list write port
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wen_q <= '0;
    end else begin
      wen_q <= step.fire ? srvl_bmp : '0;  // one cycle per step
    end
  end

  always_ff @(posedge clk) begin
    if (step.fire) begin
      waddr_q <= step.info_cnt;
    end
  end

  assign list_wr.wen   = wen_q;
  assign list_wr.waddr = waddr_q;
  assign list_wr.wdata = wdata_q;

endmodule

/* hdl/pdec_bit_seq.sv */
// ============================================================
// path update sequencer: accepts an update request, runs the
// decoded-bit steps and keeps the info bit counter
// ============================================================
`timescale 1ns/1ps

module pdec_bit_seq (
  input  logic                clk,
  input  logic                rst_n,
  input  pdec_pkg::node_cfg_t node_cfg,
  input  logic                dec_start,
  input  logic                upd_valid,
  output logic                upd_ready,
  output pdec_pkg::step_t     step,
  output logic                upd_done
);

  pdec_pkg::seq_state_e state_q;
  pdec_pkg::seq_state_e state_d;
  pdec_pkg::step_idx_t  step_cnt_q;
  pdec_pkg::step_idx_t  last_idx;
  pdec_pkg::info_cnt_t  info_cnt_q;
  logic                 accept;
  logic                 in_step;

  assign accept  = upd_valid & upd_ready;
  assign in_step = (state_q == pdec_pkg::st_step);

  // number of bit steps minus one
  always_comb begin
    last_idx = 2'd0;
    if (node_cfg.leaf_mode) begin
      case (node_cfg.jump_type)
        pdec_pkg::jt_bit2_t0,
        pdec_pkg::jt_bit2_t1: last_idx = 2'd1;
        pdec_pkg::jt_bit3:    last_idx = 2'd2;
        pdec_pkg::jt_bit4:    last_idx = 2'd3;
        default:              last_idx = 2'd0;  // rep, frozen
      endcase
    end
  end

  // ============================================================
  // FSM
  // ============================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      pdec_pkg::st_idle: begin
        if (accept) begin
          // non-leaf node fires in the accept cycle itself
          state_d = node_cfg.leaf_mode ? pdec_pkg::st_step : pdec_pkg::st_done;
        end
      end
      pdec_pkg::st_step: begin
        if (step_cnt_q == last_idx) state_d = pdec_pkg::st_done;
      end
      pdec_pkg::st_done: state_d = pdec_pkg::st_idle;
      default:           state_d = pdec_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= pdec_pkg::st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_cnt_q <= '0;
    end else if (accept) begin
      step_cnt_q <= '0;
    end else if (in_step) begin
      step_cnt_q <= step_cnt_q + 2'd1;
    end
  end

  // info position, one per fired step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      info_cnt_q <= '0;
    end else if (dec_start) begin
      info_cnt_q <= '0;
    end else if (step.fire) begin
      info_cnt_q <= info_cnt_q + 1'b1;
    end
  end

  assign step.first    = accept;
  assign step.fire     = (accept & ~node_cfg.leaf_mode) | in_step;
  assign step.idx      = in_step ? step_cnt_q : 2'd0;
  assign step.info_cnt = info_cnt_q;

  assign upd_ready = (state_q == pdec_pkg::st_idle);
  assign upd_done  = (state_q == pdec_pkg::st_done);  // one cycle after last step

endmodule

/* hdl/pdec_pkg.sv */
// ============================================================
// path update shared sizes, encodings and bundles for the
// successive-cancellation list decoder
// ============================================================

package pdec_pkg;

  // ============================================================
  // sizes
  // ============================================================
  localparam int num_path   = 8;
  localparam int path_idx_w = 3;
  localparam int pm_idx_w   = 5;
  localparam int num_cand   = 32;   // four leaf candidates per path
  localparam int num_k      = 164;
  localparam int info_cnt_w = 8;
  localparam int num_dcrc   = 3;

  typedef logic [path_idx_w-1:0] path_idx_t;
  typedef logic [pm_idx_w-1:0]   pm_idx_t;
  typedef logic [info_cnt_w-1:0] info_cnt_t;
  typedef logic [num_dcrc-1:0]   dcrc_vec_t;
  typedef logic [num_path-1:0]   path_bmp_t;
  typedef logic [3:0]            leaf_bits_t;  // bit3 down to bit0
  typedef logic [1:0]            step_idx_t;   // up to four bit steps

  // ============================================================
  // encodings
  // ============================================================
  typedef enum logic [2:0] {
    jt_frozen  = 3'd0,
    jt_rep     = 3'd1,
    jt_bit2_t0 = 3'd2,
    jt_bit2_t1 = 3'd3,
    jt_bit3    = 3'd4,
    jt_bit4    = 3'd5,
    jt_normal  = 3'd7
  } jump_type_e;

  typedef enum logic [1:0] {
    stat_ck      = 2'd0,
    stat_valid   = 2'd1,
    stat_invalid = 2'd3
  } path_stat_e;

  typedef enum logic {
    mode_cd = 1'b0,   // failed check drops the path
    mode_ck = 1'b1    // failed check only marks it
  } dcrc_mode_e;

  typedef enum logic [1:0] {
    st_idle,
    st_step,
    st_done
  } seq_state_e;

  // ============================================================
  // bundles
  // ============================================================
  typedef struct packed {
    logic                      leaf_mode;
    jump_type_e                jump_type;
    logic [1:0]                dcrc_num;   // 0 = off
    dcrc_mode_e                dcrc_mode;
    dcrc_vec_t                 dcrc_ini;
    info_cnt_t [num_dcrc-1:0]  dcrc_idx;   // check position per parity bit
  } node_cfg_t;

  typedef struct packed {
    logic      first;     // start step, parents are copied
    logic      fire;      // one decoded bit per path
    step_idx_t idx;
    info_cnt_t info_cnt;
  } step_t;

  typedef struct packed {
    logic      dec;
    path_idx_t idx;
  } list_ent_t;

  typedef struct packed {
    path_bmp_t                 wen;
    info_cnt_t                 waddr;
    list_ent_t [num_path-1:0]  wdata;
  } list_wr_t;

endpackage
